/* source/id_pkg.sv */
package id_pkg;

   ////////////////////////////////////////
   // Widths
   ////////////////////////////////////////
   localparam int NB_REG      = 32;
   localparam int NB_REG_ADDR = 5;
   localparam int NB_INM      = 16;
   localparam int NB_SHAMT    = 5;
   localparam int NB_J_INM    = 26;
   localparam int NB_OPCODE   = 6;
   localparam int NB_FUNC     = 6;
   localparam int NB_ALU_OP   = 4;

   // Link register for JAL
   localparam logic [NB_REG_ADDR-1:0] RA_ADDR = {NB_REG_ADDR{1'b1}};

   // Instruction field positions
   localparam int MSB_OPCODE = 31;
   localparam int MSB_RS     = 25;
   localparam int MSB_RT     = 20;
   localparam int MSB_RD     = 15;
   localparam int MSB_SHAMT  = 10;
   localparam int MSB_INM    = 15;
   localparam int MSB_FUNC   = 5;
   localparam int MSB_J_INM  = 25;

   ////////////////////////////////////////
   // Encodings
   ////////////////////////////////////////
   typedef enum logic [NB_OPCODE-1:0] {
      R_INST = 6'b000000,
      LB     = 6'b100000,
      LH     = 6'b100001,
      LW     = 6'b100011,
      LBU    = 6'b100100,
      LHU    = 6'b100101,
      LWU    = 6'b100111,
      SB     = 6'b101000,
      SH     = 6'b101001,
      SW     = 6'b101011,
      ADDI   = 6'b001001,
      ANDI   = 6'b001100,
      ORI    = 6'b001101,
      XORI   = 6'b001110,
      LUI    = 6'b001111,
      SLTI   = 6'b001010,
      BEQ    = 6'b000100,
      BNE    = 6'b000101,
      J      = 6'b000010,
      JAL    = 6'b000011
   } opcode_e;

   typedef enum logic [NB_FUNC-1:0] {
      FUNC_SLL  = 6'b000000,
      FUNC_SRL  = 6'b000010,
      FUNC_SRA  = 6'b000011,
      FUNC_SLLV = 6'b000100,
      FUNC_SRLV = 6'b000110,
      FUNC_SRAV = 6'b000111,
      FUNC_JR   = 6'b001000,
      FUNC_JALR = 6'b001001,
      FUNC_ADDU = 6'b100001,
      FUNC_SUBU = 6'b100011,
      FUNC_AND  = 6'b100100,
      FUNC_OR   = 6'b100101,
      FUNC_XOR  = 6'b100110,
      FUNC_NOR  = 6'b100111,
      FUNC_SLT  = 6'b101010
   } funct_e;

   typedef enum logic [NB_ALU_OP-1:0] {
      ADD    = 4'b0000,
      SUB    = 4'b0001,
      AND    = 4'b0010,
      OR     = 4'b0011,
      XOR    = 4'b0100,
      NOR    = 4'b0101,
      SRL    = 4'b0110,
      SLL    = 4'b0111,
      SRA    = 4'b1000,
      SLA    = 4'b1001,
      SLT    = 4'b1010,
      LUI_OP = 4'b1011
   } alu_op_e;

   ////////////////////////////////////////
   // Control frames
   ////////////////////////////////////////
   typedef struct packed {
      alu_op_e alu_op;
      logic    use_imm;
      logic    zero_ext;
      logic    use_shamt;
   } ex_ctrl_t;

   // size: 0 byte, 1 half, 2 word
   typedef struct packed {
      logic       rd_en;
      logic       wr_en;
      logic       unsigned_ld;
      logic [1:0] size;
   } mem_ctrl_t;

   typedef struct packed {
      logic [NB_REG_ADDR-1:0] dest;
      logic                   reg_we;
      logic                   from_alu;
      logic                   link_pc;
   } wb_ctrl_t;

   typedef struct packed {
      ex_ctrl_t  ex;
      mem_ctrl_t mem;
      wb_ctrl_t  wb;
      logic      is_branch;
      logic      branch_ne;
      logic      jump_reg;
      logic      jump_imm;
   } dec_ctrl_t;

endpackage

/* source/register_file.sv */
`timescale 1ns/1ns

module register_file #(
   parameter int DATA_W = 32,
   parameter int ADDR_W = 5
) (
   input  logic              i_clk,
   input  logic              i_rst,
   input  logic [ADDR_W-1:0] i_rd_addr_a,
   input  logic [ADDR_W-1:0] i_rd_addr_b,
   output logic [DATA_W-1:0] o_rd_data_a,
   output logic [DATA_W-1:0] o_rd_data_b,
   input  logic [ADDR_W-1:0] i_wr_addr,
   input  logic [DATA_W-1:0] i_wr_data,
   input  logic              i_wr_en
);

   localparam int DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] regs [DEPTH];

   // Write on the falling edge so a same-cycle read sees new data
   always_ff @(negedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            regs[i] <= '0;
         end
      end else if (i_wr_en) begin
         regs[i_wr_addr] <= i_wr_data;
      end
   end

   // Asynchronous reads
   assign o_rd_data_a = regs[i_rd_addr_a];
   assign o_rd_data_b = regs[i_rd_addr_b];

endmodule

/* source/opcode_decoder.sv */
`timescale 1ns/1ns

module opcode_decoder import id_pkg::*; (
   input  opcode_e                i_opcode,
   input  funct_e                 i_funct,
   input  logic [NB_REG_ADDR-1:0] i_rt,
   input  logic [NB_REG_ADDR-1:0] i_rd,
   output dec_ctrl_t              o_ctrl
);

   // Function table outputs
   logic      func_ok;
   alu_op_e   f_alu_op;
   logic      f_use_shamt;
   logic      f_link_pc;
   logic      f_jump_reg;
   logic      f_reg_we;

   logic      frame_ok;
   dec_ctrl_t frame;

   // Access size from the low opcode bits
   function automatic logic [1:0] mem_size(input opcode_e op);
      case (op)
         LB, LBU, SB: mem_size = 2'd0;
         LH, LHU, SH: mem_size = 2'd1;
         default:     mem_size = 2'd2;
      endcase
   endfunction

   ////////////////////////////////////////
   // Function-code table
   ////////////////////////////////////////
   always_comb begin
      func_ok     = 1'b1;
      f_alu_op    = ADD;
      f_use_shamt = 1'b0;
      f_link_pc   = 1'b0;
      f_jump_reg  = 1'b0;
      f_reg_we    = 1'b1;
      case (i_funct)
         FUNC_SLL: begin
            f_alu_op    = SLL;
            f_use_shamt = 1'b1;
         end
         FUNC_SRL: begin
            f_alu_op    = SRL;
            f_use_shamt = 1'b1;
         end
         FUNC_SRA: begin
            f_alu_op    = SRA;
            f_use_shamt = 1'b1;
         end
         FUNC_SLLV: f_alu_op = SLL;
         FUNC_SRLV: f_alu_op = SRL;
         FUNC_SRAV: f_alu_op = SRA;
         FUNC_ADDU: f_alu_op = ADD;
         FUNC_SUBU: f_alu_op = SUB;
         FUNC_AND:  f_alu_op = AND;
         FUNC_OR:   f_alu_op = OR;
         FUNC_XOR:  f_alu_op = XOR;
         FUNC_NOR:  f_alu_op = NOR;
         FUNC_SLT:  f_alu_op = SLT;
         FUNC_JR: begin
            f_jump_reg = 1'b1;
            f_reg_we   = 1'b0;
         end
         FUNC_JALR: begin
            f_jump_reg = 1'b1;
            f_link_pc  = 1'b1;
         end
         default: func_ok = 1'b0;
      endcase
   end

   ////////////////////////////////////////
   // Main table
   ////////////////////////////////////////
   always_comb begin
      frame    = '0;
      frame_ok = 1'b1;
      case (i_opcode)
         R_INST: begin
            frame_ok           = func_ok;
            // Shift amount only ever comes from here
            frame.ex.alu_op    = f_alu_op;
            frame.ex.use_shamt = f_use_shamt;
            frame.wb.reg_we    = f_reg_we;
            frame.wb.from_alu  = 1'b1;
            frame.wb.link_pc   = f_link_pc;
            frame.jump_reg     = f_jump_reg;
         end
         LB, LH, LW, LBU, LHU, LWU: begin
            frame.ex.use_imm      = 1'b1;
            frame.mem.rd_en       = 1'b1;
            frame.mem.unsigned_ld = i_opcode inside {LBU, LHU, LWU};
            frame.mem.size        = mem_size(i_opcode);
            frame.wb.reg_we       = 1'b1;
         end
         SB, SH, SW: begin
            frame.ex.use_imm = 1'b1;
            frame.mem.wr_en  = 1'b1;
            frame.mem.size   = mem_size(i_opcode);
         end
         ADDI, SLTI, ANDI, ORI, XORI, LUI: begin
            frame.ex.use_imm   = 1'b1;
            frame.ex.zero_ext  = i_opcode inside {ANDI, ORI, XORI, LUI};
            frame.wb.reg_we    = 1'b1;
            frame.wb.from_alu  = 1'b1;
            case (i_opcode)
               SLTI:    frame.ex.alu_op = SLT;
               ANDI:    frame.ex.alu_op = AND;
               ORI:     frame.ex.alu_op = OR;
               XORI:    frame.ex.alu_op = XOR;
               LUI:     frame.ex.alu_op = LUI_OP;
               default: frame.ex.alu_op = ADD;
            endcase
         end
         BEQ, BNE: begin
            frame.ex.use_imm = 1'b1;
            frame.is_branch  = 1'b1;
            frame.branch_ne  = (i_opcode == BNE);
         end
         J: frame.jump_imm = 1'b1;
         JAL: begin
            frame.jump_imm   = 1'b1;
            frame.wb.reg_we  = 1'b1;
            frame.wb.link_pc = 1'b1;
         end
         default: frame_ok = 1'b0;
      endcase

      if (!frame_ok) begin
         frame = '0;
      end else begin
         if (i_opcode == JAL) begin
            frame.wb.dest = RA_ADDR;
         end else if (frame.ex.use_imm) begin
            frame.wb.dest = i_rt;
         end else begin
            frame.wb.dest = i_rd;
         end
         // Register 0 is never written
         frame.wb.reg_we = frame.wb.reg_we & (|frame.wb.dest);
      end
   end

   assign o_ctrl = frame;

endmodule

/* source/branch_resolver.sv */
`timescale 1ns/1ns

module branch_resolver import id_pkg::*; (
   input  logic              i_clk,
   input  logic              i_rst,
   input  dec_ctrl_t         i_ctrl,
   input  logic [NB_REG-1:0] i_rs_val,
   input  logic [NB_REG-1:0] i_rt_val,
   output logic              o_branch,
   output logic              o_flush
);

   logic equal;
   logic taken;

   // BNE inverts the compare
   assign equal = (i_rs_val == i_rt_val);
   assign taken = i_ctrl.is_branch & (equal ^ i_ctrl.branch_ne);

   assign o_branch = i_ctrl.is_branch;

   // Kill the wrong-path instruction next cycle
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_flush <= 1'b0;
      end else begin
         o_flush <= taken | i_ctrl.jump_reg | i_ctrl.jump_imm;
      end
   end

endmodule

/* source/id_pipe_regs.sv */
`timescale 1ns/1ns

module id_pipe_regs import id_pkg::*; (
   input  logic                i_clk,
   input  logic                i_rst,
   input  dec_ctrl_t           i_ctrl,
   input  logic [NB_REG-1:0]   i_rs_val,
   input  logic [NB_REG-1:0]   i_rt_val,
   input  logic [NB_INM-1:0]   i_inm,
   input  logic [NB_SHAMT-1:0] i_shamt,
   input  logic [NB_REG-1:0]   i_pc,
   output ex_ctrl_t            o_ex_ctrl,
   output mem_ctrl_t           o_mem_ctrl,
   output wb_ctrl_t            o_wb_ctrl,
   output logic [NB_REG-1:0]   o_a,
   output logic [NB_REG-1:0]   o_b,
   output logic [NB_INM-1:0]   o_inm,
   output logic [NB_SHAMT-1:0] o_shamt,
   output logic [NB_REG-1:0]   o_pc
);

   ////////////////////////////////////////
   // Control frames
   ////////////////////////////////////////
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_ex_ctrl  <= '0;
         o_mem_ctrl <= '0;
         o_wb_ctrl  <= '0;
      end else begin
         o_ex_ctrl  <= i_ctrl.ex;
         o_mem_ctrl <= i_ctrl.mem;
         o_wb_ctrl  <= i_ctrl.wb;
      end
   end

   ////////////////////////////////////////
   // Data path
   ////////////////////////////////////////
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_a  <= '0;
         o_b  <= '0;
         o_pc <= '0;
      end else begin
         o_a  <= i_rs_val;
         o_b  <= i_rt_val;
         o_pc <= i_pc;
      end
   end

   // Raw instruction fields
   always_ff @(posedge i_clk) begin
      o_inm   <= i_inm;
      o_shamt <= i_shamt;
   end

endmodule

/* source/id_stage.sv */
`timescale 1ns/1ns

module id_stage import id_pkg::*; (
   input  logic                   i_clk,
   input  logic                   i_rst,
   input  logic [NB_REG-1:0]      i_instruction,
   input  logic [NB_REG-1:0]      i_pc,
   input  logic [NB_REG_ADDR-1:0] i_wb_addr,
   input  logic [NB_REG-1:0]      i_wb_data,
   input  logic                   i_wb_we,
   output ex_ctrl_t               o_ex_ctrl,
   output mem_ctrl_t              o_mem_ctrl,
   output wb_ctrl_t               o_wb_ctrl,
   output logic [NB_REG-1:0]      o_a,
   output logic [NB_REG-1:0]      o_b,
   output logic [NB_INM-1:0]      o_inm,
   output logic [NB_SHAMT-1:0]    o_shamt,
   output logic [NB_REG-1:0]      o_pc,
   output logic                   o_branch,
   output logic                   o_flush,
   output logic                   o_jump_rs,
   output logic [NB_REG-1:0]      o_jump_rs_addr,
   output logic                   o_jump_inm,
   output logic [NB_J_INM-1:0]    o_jump_inm_addr
);

   opcode_e                opcode;
   funct_e                 funct;
   logic [NB_REG_ADDR-1:0] rs;
   logic [NB_REG_ADDR-1:0] rt;
   logic [NB_REG_ADDR-1:0] rd;
   logic [NB_INM-1:0]      inm;
   logic [NB_SHAMT-1:0]    shamt;
   dec_ctrl_t              ctrl;
   logic [NB_REG-1:0]      rs_val;
   logic [NB_REG-1:0]      rt_val;

   ////////////////////////////////////////
   // Field extraction
   ////////////////////////////////////////
   assign opcode = opcode_e'(i_instruction[MSB_OPCODE -: NB_OPCODE]);
   assign funct  = funct_e'(i_instruction[MSB_FUNC -: NB_FUNC]);
   assign rs     = i_instruction[MSB_RS -: NB_REG_ADDR];
   assign rt     = i_instruction[MSB_RT -: NB_REG_ADDR];
   assign rd     = i_instruction[MSB_RD -: NB_REG_ADDR];
   assign inm    = i_instruction[MSB_INM -: NB_INM];
   assign shamt  = i_instruction[MSB_SHAMT -: NB_SHAMT];

   // Jump requests go straight back to fetch
   assign o_jump_rs       = ctrl.jump_reg;
   assign o_jump_rs_addr  = rs_val;
   assign o_jump_inm      = ctrl.jump_imm;
   assign o_jump_inm_addr = i_instruction[MSB_J_INM -: NB_J_INM];

   register_file #(
      .DATA_W (NB_REG),
      .ADDR_W (NB_REG_ADDR)
   ) u_register_file (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_rd_addr_a (rs),
      .i_rd_addr_b (rt),
      .o_rd_data_a (rs_val),
      .o_rd_data_b (rt_val),
      .i_wr_addr   (i_wb_addr),
      .i_wr_data   (i_wb_data),
      .i_wr_en     (i_wb_we)
   );

   opcode_decoder u_opcode_decoder (
      .i_opcode (opcode),
      .i_funct  (funct),
      .i_rt     (rt),
      .i_rd     (rd),
      .o_ctrl   (ctrl)
   );

   branch_resolver u_branch_resolver (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_ctrl   (ctrl),
      .i_rs_val (rs_val),
      .i_rt_val (rt_val),
      .o_branch (o_branch),
      .o_flush  (o_flush)
   );

   id_pipe_regs u_id_pipe_regs (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_ctrl     (ctrl),
      .i_rs_val   (rs_val),
      .i_rt_val   (rt_val),
      .i_inm      (inm),
      .i_shamt    (shamt),
      .i_pc       (i_pc),
      .o_ex_ctrl  (o_ex_ctrl),
      .o_mem_ctrl (o_mem_ctrl),
      .o_wb_ctrl  (o_wb_ctrl),
      .o_a        (o_a),
      .o_b        (o_b),
      .o_inm      (o_inm),
      .o_shamt    (o_shamt),
      .o_pc       (o_pc)
   );

endmodule

/* verif/tb_id_stage.sv */
`timescale 1ns/1ns

module tb_id_stage import id_pkg::*; ();

   localparam int          PRELOAD_REGS = 31;
   localparam logic [31:0] PC_BASE      = 32'h0040_0000;

   // One line of the pattern file
   typedef struct packed {
      logic [NB_REG-1:0] instr;
      ex_ctrl_t          ex;
      mem_ctrl_t         mem;
      wb_ctrl_t          wb;
      logic              flush;
   } pattern_t;

   logic                   i_clk;
   logic                   i_rst;
   logic [NB_REG-1:0]      i_instruction;
   logic [NB_REG-1:0]      i_pc;
   logic [NB_REG_ADDR-1:0] i_wb_addr;
   logic [NB_REG-1:0]      i_wb_data;
   logic                   i_wb_we;
   ex_ctrl_t               o_ex_ctrl;
   mem_ctrl_t              o_mem_ctrl;
   wb_ctrl_t               o_wb_ctrl;
   logic [NB_REG-1:0]      o_a;
   logic [NB_REG-1:0]      o_b;
   logic [NB_INM-1:0]      o_inm;
   logic [NB_SHAMT-1:0]    o_shamt;
   logic [NB_REG-1:0]      o_pc;
   logic                   o_branch;
   logic                   o_flush;
   logic                   o_jump_rs;
   logic [NB_REG-1:0]      o_jump_rs_addr;
   logic                   o_jump_inm;
   logic [NB_J_INM-1:0]    o_jump_inm_addr;

   pattern_t          patterns[$];
   logic [NB_REG-1:0] shadow [32];
   logic [31:0]       rng_state   = 32'd62;
   int                cycle_count = 0;
   int                cycle_limit = 100;

   id_stage i_id_stage (.*);

   always #2 i_clk = ~i_clk;

   always @(posedge i_clk) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         stop_with_failure($sformatf("Timeout: the run did not end within %0d cycles",
                                     cycle_limit));
      end
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////
   function automatic logic [31:0] xorshift32(input logic [31:0] state);
      logic [31:0] x;
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("Simulation FAILED");
      $fatal(1, "Run stopped");
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         stop_with_failure($sformatf("[ERROR] %0t ns: %s expected %h, got %h",
                                     $time, what, expected, got));
      end
   endtask

   task automatic load_patterns();
      int                fd;
      int                n;
      string             line;
      logic [31:0]       f_instr;
      logic [31:0]       f_ex;
      logic [31:0]       f_mem;
      logic [31:0]       f_wb;
      logic [31:0]       f_flush;
      pattern_t          pat;
      fd = $fopen("verif/id_patterns.txt", "r");
      if (fd == 0) begin
         stop_with_failure("Pattern file verif/id_patterns.txt could not be opened");
      end
      // Comment lines fail the scan and drop out
      while ($fgets(line, fd) != 0) begin
         n = $sscanf(line, "%h %h %h %h %h", f_instr, f_ex, f_mem, f_wb, f_flush);
         if (n == 5) begin
            pat.instr = f_instr;
            pat.ex    = ex_ctrl_t'(f_ex[6:0]);
            pat.mem   = mem_ctrl_t'(f_mem[4:0]);
            pat.wb    = wb_ctrl_t'(f_wb[7:0]);
            pat.flush = f_flush[0];
            patterns.push_back(pat);
         end
      end
      $fclose(fd);
   endtask

   task automatic check_registered(input pattern_t pat, input logic [31:0] exp_a,
                                   input logic [31:0] exp_b, input logic [31:0] exp_pc);
      string tag;
      tag = $sformatf(" (instr %h)", pat.instr);
      check_value({"o_ex_ctrl", tag}, o_ex_ctrl, pat.ex);
      check_value({"o_mem_ctrl", tag}, o_mem_ctrl, pat.mem);
      check_value({"o_wb_ctrl", tag}, o_wb_ctrl, pat.wb);
      check_value({"o_a", tag}, o_a, exp_a);
      check_value({"o_b", tag}, o_b, exp_b);
      check_value({"o_pc", tag}, o_pc, exp_pc);
      check_value({"o_inm", tag}, o_inm, pat.instr[MSB_INM -: NB_INM]);
      check_value({"o_shamt", tag}, o_shamt, pat.instr[MSB_SHAMT -: NB_SHAMT]);
      check_value({"o_flush", tag}, o_flush, pat.flush);
   endtask

   // Same-cycle outputs, sampled after the falling-edge write
   task automatic check_jumps(input logic [31:0] instr);
      logic [NB_OPCODE-1:0]   opcode;
      logic [NB_FUNC-1:0]     funct;
      logic [NB_REG_ADDR-1:0] rs;
      logic                   exp_jump_rs;
      opcode      = instr[MSB_OPCODE -: NB_OPCODE];
      funct       = instr[MSB_FUNC -: NB_FUNC];
      rs          = instr[MSB_RS -: NB_REG_ADDR];
      exp_jump_rs = (opcode == R_INST) && (funct == FUNC_JR || funct == FUNC_JALR);
      check_value("o_jump_rs", o_jump_rs, exp_jump_rs);
      check_value("o_jump_inm", o_jump_inm, opcode == J || opcode == JAL);
      check_value("o_branch", o_branch, opcode == BEQ || opcode == BNE);
      check_value("o_jump_rs_addr", o_jump_rs_addr, shadow[rs]);
      check_value("o_jump_inm_addr", o_jump_inm_addr, instr[MSB_J_INM -: NB_J_INM]);
   endtask

   task automatic preload_registers();
      for (int r = 1; r <= PRELOAD_REGS; r++) begin
         @(posedge i_clk);
         #1;
         rng_state = xorshift32(rng_state);
         i_wb_we   = 1'b1;
         i_wb_addr = 5'(r);
         i_wb_data = rng_state;
         shadow[r] = rng_state;
      end
   endtask

   task automatic run_patterns();
      logic [31:0]            instr;
      logic [NB_REG_ADDR-1:0] wr_addr;
      logic [31:0]            exp_a;
      logic [31:0]            exp_b;
      logic [31:0]            exp_pc;
      pattern_t               exp_pat;
      logic                   pending;
      pending = 1'b0;
      exp_a   = '0;
      exp_b   = '0;
      exp_pc  = '0;
      exp_pat = '0;
      for (int k = 0; k < patterns.size(); k++) begin
         @(posedge i_clk);
         #1;
         if (pending) begin
            check_registered(exp_pat, exp_a, exp_b, exp_pc);
         end
         // Each instruction shares its cycle with a register write
         instr     = patterns[k].instr;
         wr_addr   = 5'((k % PRELOAD_REGS) + 1);
         rng_state = xorshift32(rng_state);
         i_instruction   = instr;
         i_pc            = PC_BASE + (k << 2);
         i_wb_we         = 1'b1;
         i_wb_addr       = wr_addr;
         i_wb_data       = rng_state;
         shadow[wr_addr] = rng_state;
         exp_a   = shadow[instr[MSB_RS -: NB_REG_ADDR]];
         exp_b   = shadow[instr[MSB_RT -: NB_REG_ADDR]];
         exp_pc  = i_pc;
         exp_pat = patterns[k];
         pending = 1'b1;
         #2;
         check_jumps(instr);
      end
      @(posedge i_clk);
      #1;
      if (pending) begin
         check_registered(exp_pat, exp_a, exp_b, exp_pc);
      end
      i_wb_we       = 1'b0;
      i_instruction = '0;
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////
   initial begin
      i_clk         = 1'b0;
      i_rst         = 1'b1;
      i_instruction = '0;
      i_pc          = '0;
      i_wb_addr     = '0;
      i_wb_data     = '0;
      i_wb_we       = 1'b0;
      for (int r = 0; r < 32; r++) begin
         shadow[r] = '0;
      end

      load_patterns();
      cycle_limit = 2 * (PRELOAD_REGS + patterns.size()) + 20;

      repeat (3) @(posedge i_clk);
      #1;
      check_value("o_ex_ctrl after reset", o_ex_ctrl, '0);
      check_value("o_mem_ctrl after reset", o_mem_ctrl, '0);
      check_value("o_wb_ctrl after reset", o_wb_ctrl, '0);
      check_value("o_a after reset", o_a, '0);
      check_value("o_b after reset", o_b, '0);
      check_value("o_pc after reset", o_pc, '0);
      check_value("o_flush after reset", o_flush, '0);
      i_rst = 1'b0;

      preload_registers();
      run_patterns();

      $display("Simulation PASSED");
      $finish;
   end

endmodule

/* verif/id_patterns.txt */
// instruction  ex  mem  wb  flush   (all hex; ex, mem, wb are the packed control frames)
// flush is the expected o_flush one cycle after the instruction
00221821 00 00 1E 0  addu $3,$1,$2
00A62023 08 00 26 0  subu $4,$5,$6
01093824 10 00 3E 0  and $7,$8,$9
016C5025 18 00 56 0  or $10,$11,$12
01CF6826 20 00 6E 0  xor $13,$14,$15
02328027 28 00 86 0  nor $16,$17,$18
0295982A 50 00 9E 0  slt $19,$20,$21
0017B140 39 00 B6 0  sll $22,$23,5
0019C7C2 31 00 C6 0  srl $24,$25,31
001BD043 41 00 D6 0  sra $26,$27,1
03DDE004 38 00 E6 0  sllv $28,$29,$30
0041F806 30 00 FE 0  srlv $31,$1,$2
00830007 40 00 02 0  srav $0,$3,$4
00A00008 00 00 02 1  jr $5
00C0F809 00 00 FF 1  jalr $31,$6
81070004 04 10 3C 0  lb $7,4($8)
8549FFFE 04 11 4C 0  lh $9,-2($10)
8D8B0008 04 12 5C 0  lw $11,8($12)
91CD0000 04 14 6C 0  lbu $13,0($14)
960F0002 04 15 7C 0  lhu $15,2($16)
9E51000C 04 16 8C 0  lwu $17,12($18)
A2930001 04 08 98 0  sb $19,1($20)
A6D50002 04 09 A8 0  sh $21,2($22)
AF170004 04 0A B8 0  sw $23,4($24)
2759FFFF 04 00 CE 0  addi $25,$26,-1
339B00FF 16 00 DE 0  andi $27,$28,0xff
37DD1234 1E 00 EE 0  ori $29,$30,0x1234
3BFE8000 26 00 F6 0  xori $30,$31,0x8000
3C01ABCD 5E 00 0E 0  lui $1,0xabcd
28620064 54 00 16 0  slti $2,$3,100
10A50010 04 00 28 1  beq $5,$5 taken
10220008 04 00 10 0  beq $1,$2 not taken
14C7FFFC 04 00 38 1  bne $6,$7 taken
15080004 04 00 40 0  bne $8,$8 not taken
10000001 04 00 00 1  beq $0,$0 taken
08123456 00 00 30 1  j 0x0123456
0FFFFFFF 00 00 FD 1  jal 0x3ffffff
FC221821 00 00 00 0  unknown opcode
00221820 00 00 00 0  unknown function code

/* id_stage.f */
source/id_pkg.sv
source/register_file.sv
source/opcode_decoder.sv
source/branch_resolver.sv
source/id_pipe_regs.sv
source/id_stage.sv
verif/tb_id_stage.sv

/* Bender.yml */
package:
  name: id_stage

sources:
  - source/id_pkg.sv
  - source/register_file.sv
  - source/opcode_decoder.sv
  - source/branch_resolver.sv
  - source/id_pipe_regs.sv
  - source/id_stage.sv
  - target: test
    files:
      - verif/tb_id_stage.sv
